//--- compile.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/addr_map.sv
hdl/fetch_port.sv
hdl/data_port.sv
hdl/bus_arbiter.sv
hdl/mem_access_top.sv
tests/tb_mem_access.sv

//--- hdl/addr_map.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module addr_map (
	input  mem_pkg::vaddr_t vaddr_i,
	output mem_pkg::paddr_t paddr_o,
	output logic            uncached_o
);

	// address falls in kseg0 or kseg1
	logic in_kseg01;
	// address falls in kseg1 only
	logic in_kseg1;

	// both kernel segments sit between kseg0 base and kseg2 base
	assign in_kseg01 = (vaddr_i >= `MEM_KSEG0_BASE) && (vaddr_i < `MEM_KSEG2_BASE);
	// upper half of that window is the uncached alias
	assign in_kseg1 = (vaddr_i >= `MEM_KSEG1_BASE) && (vaddr_i < `MEM_KSEG2_BASE);

	// strip segment bits in kseg0/kseg1, pass everything else through
	assign paddr_o = in_kseg01 ? (vaddr_i & `MEM_PHYS_MASK) : vaddr_i;

	// only kseg1 bypasses caching
	assign uncached_o = in_kseg1;

endmodule

`default_nettype wire

//--- hdl/bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
	input  logic            clk,
	input  logic            rst,
	// fetch port
	input  logic            ireq_i,
	input  mem_pkg::paddr_t ipaddr_i,
	input  logic            iuncached_i,
	output logic            idone_o,
	output mem_pkg::word_t  irdata_o,
	// data port
	input  logic            dreq_i,
	input  mem_pkg::paddr_t dpaddr_i,
	input  logic            duncached_i,
	input  logic            dwe_i,
	input  mem_pkg::word_t  dwdata_i,
	input  mem_pkg::wsel_t  dwsel_i,
	output logic            ddone_o,
	output mem_pkg::word_t  drdata_o,
	// shared memory bus
	output logic            bus_req_o,
	output mem_pkg::paddr_t bus_addr_o,
	output logic            bus_uncached_o,
	output logic            bus_we_o,
	output mem_pkg::word_t  bus_wdata_o,
	output mem_pkg::wsel_t  bus_wsel_o,
	input  logic            bus_ack_i,
	input  mem_pkg::word_t  bus_rdata_i
);
	import mem_pkg::*;

	arb_state_t state_q;
	arb_state_t state_d;
	logic       grant_data;

	////////////////////////////////////////
	// grant fsm
	////////////////////////////////////////

	// data wins over fetch, then hold until ack
	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (dreq_i)
					state_d = ARB_DATA;
				else if (ireq_i)
					state_d = ARB_INST;
			end
			ARB_INST, ARB_DATA: begin
				if (bus_ack_i)
					state_d = ARB_IDLE;
			end
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= ARB_IDLE;
		else
			state_q <= state_d;
	end

	// one-cycle strobe on entry to a granted state
	always_ff @(posedge clk) begin
		if (rst)
			bus_req_o <= 1'b0;
		else
			bus_req_o <= (state_q == ARB_IDLE) && (dreq_i || ireq_i);
	end

	////////////////////////////////////////
	// bus mux and completion steering
	////////////////////////////////////////

	assign grant_data = (state_q == ARB_DATA);

	// ports hold their fields, so a plain mux on the grant is stable
	assign bus_addr_o     = grant_data ? dpaddr_i : ipaddr_i;
	assign bus_uncached_o = grant_data ? duncached_i : iuncached_i;
	assign bus_we_o       = grant_data & dwe_i;
	assign bus_wdata_o    = dwdata_i;
	// reads present every byte lane
	assign bus_wsel_o     = (grant_data && dwe_i) ? dwsel_i : 4'hF;

	// done in the same cycle as the ack
	assign idone_o = (state_q == ARB_INST) & bus_ack_i;
	assign ddone_o = grant_data & bus_ack_i;

	// read data fans out, the done strobe says who owns it
	assign irdata_o = bus_rdata_i;
	assign drdata_o = bus_rdata_i;

endmodule

`default_nettype wire

//--- hdl/data_port.sv
`timescale 1ns/100ps
`default_nettype none

module data_port (
	input  logic            clk,
	input  logic            rst,
	// cpu read strobe
	input  logic            data_rreq_i,
	input  mem_pkg::vaddr_t data_raddr_i,
	// cpu write strobe
	input  logic            data_wreq_i,
	input  mem_pkg::vaddr_t data_waddr_i,
	input  mem_pkg::word_t  data_wdata_i,
	input  mem_pkg::wsel_t  data_wsel_i,
	// held request towards the arbiter
	output logic            dreq_o,
	output mem_pkg::paddr_t dpaddr_o,
	output logic            duncached_o,
	output logic            dwe_o,
	output mem_pkg::word_t  dwdata_o,
	output mem_pkg::wsel_t  dwsel_o,
	input  logic            ddone_i,
	input  mem_pkg::word_t  drdata_i,
	// cpu status and read return
	output logic            data_stall_o,
	output logic            data_rvalid_o,
	output mem_pkg::word_t  data_rdata_o
);
	import mem_pkg::*;

	vaddr_t sel_vaddr;
	paddr_t xlat_paddr;
	logic   xlat_uncached;
	// one access in flight, doubles as the stall
	logic   busy_q;
	logic   accept;
	paddr_t paddr_q;
	logic   uncached_q;
	logic   we_q;
	word_t  wdata_q;
	wsel_t  wsel_q;

	// read takes the address when both strobes fire
	assign sel_vaddr = data_rreq_i ? data_raddr_i : data_waddr_i;

	addr_map u_dmap (
		.vaddr_i    (sel_vaddr),
		.paddr_o    (xlat_paddr),
		.uncached_o (xlat_uncached)
	);

	// nothing new is taken while stalled
	assign accept = (data_rreq_i | data_wreq_i) & ~busy_q;

	////////////////////////////////////////
	// access tracking
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			busy_q <= 1'b0;
		else if (accept)
			busy_q <= 1'b1;
		else if (ddone_i)
			busy_q <= 1'b0;
	end

	// request fields frozen until done
	always_ff @(posedge clk) begin
		if (accept) begin
			paddr_q    <= xlat_paddr;
			uncached_q <= xlat_uncached;
			we_q       <= ~data_rreq_i;
			wdata_q    <= data_wdata_i;
			wsel_q     <= data_wsel_i;
		end
	end

	assign dreq_o      = busy_q;
	assign dpaddr_o    = paddr_q;
	assign duncached_o = uncached_q;
	assign dwe_o       = we_q;
	assign dwdata_o    = wdata_q;
	assign dwsel_o     = wsel_q;

	// stall drops the cycle after done
	assign data_stall_o = busy_q;

	////////////////////////////////////////
	// read return
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			data_rvalid_o <= 1'b0;
		else
			data_rvalid_o <= ddone_i & ~we_q;
	end

	always_ff @(posedge clk) begin
		if (ddone_i && !we_q)
			data_rdata_o <= drdata_i;
	end

endmodule

`default_nettype wire

//--- hdl/fetch_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module fetch_port (
	input  logic            clk,
	input  logic            rst,
	// cpu fetch strobe
	input  logic            inst_req_i,
	input  mem_pkg::vaddr_t inst_vaddr_i,
	input  logic            flush_i,
	input  mem_pkg::vaddr_t redirect_pc_i,
	// held request towards the arbiter
	output logic            ireq_o,
	output mem_pkg::paddr_t ipaddr_o,
	output logic            iuncached_o,
	input  logic            idone_i,
	input  mem_pkg::word_t  irdata_i,
	// completion back to the cpu
	output logic            inst_valid_o,
	output mem_pkg::word_t  inst_o,
	output mem_pkg::vaddr_t inst_addr_o,
	output mem_pkg::vaddr_t npc_o
);
	import mem_pkg::*;

	paddr_t xlat_paddr;
	logic   xlat_uncached;
	// one fetch in flight
	logic   busy_q;
	// in-flight fetch was flushed
	logic   discard_q;
	vaddr_t pc_q;
	paddr_t paddr_q;
	logic   uncached_q;
	logic   accept;
	logic   deliver;

	addr_map u_imap (
		.vaddr_i    (inst_vaddr_i),
		.paddr_o    (xlat_paddr),
		.uncached_o (xlat_uncached)
	);

	// strobes while busy are dropped
	assign accept = inst_req_i & ~busy_q;
	// a flush in the done cycle also kills the fetch
	assign deliver = idone_i & ~discard_q & ~flush_i;

	////////////////////////////////////////
	// request tracking
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q    <= 1'b0;
			discard_q <= 1'b0;
		end else begin
			if (accept)
				busy_q <= 1'b1;
			else if (idone_i)
				busy_q <= 1'b0;
			// flush only matters for a fetch already in flight
			if (idone_i)
				discard_q <= 1'b0;
			else if (flush_i && busy_q)
				discard_q <= 1'b1;
		end
	end

	// capture pc and translation with the strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_q       <= inst_vaddr_i;
			paddr_q    <= xlat_paddr;
			uncached_q <= xlat_uncached;
		end
	end

	assign ireq_o      = busy_q;
	assign ipaddr_o    = paddr_q;
	assign iuncached_o = uncached_q;

	////////////////////////////////////////
	// completion and next pc
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			inst_valid_o <= 1'b0;
		else
			inst_valid_o <= deliver;
	end

	// word and its virtual pc, one cycle after done
	always_ff @(posedge clk) begin
		if (deliver) begin
			inst_o      <= irdata_i;
			inst_addr_o <= pc_q;
		end
	end

	// redirect beats sequential advance
	always_ff @(posedge clk) begin
		if (rst)
			npc_o <= `MEM_RESET_PC;
		else if (flush_i)
			npc_o <= redirect_pc_i;
		else if (inst_valid_o)
			npc_o <= inst_addr_o + `MEM_INST_STEP;
	end

endmodule

`default_nettype wire

//--- hdl/mem_access_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_top (
	input  logic            clk,
	input  logic            rst,
	// cpu fetch side
	input  logic            inst_req_i,
	input  mem_pkg::vaddr_t inst_vaddr_i,
	input  logic            flush_i,
	input  mem_pkg::vaddr_t redirect_pc_i,
	output logic            inst_valid_o,
	output mem_pkg::word_t  inst_o,
	output mem_pkg::vaddr_t inst_addr_o,
	output mem_pkg::vaddr_t npc_o,
	// cpu data side
	input  logic            data_rreq_i,
	input  mem_pkg::vaddr_t data_raddr_i,
	input  logic            data_wreq_i,
	input  mem_pkg::vaddr_t data_waddr_i,
	input  mem_pkg::word_t  data_wdata_i,
	input  mem_pkg::wsel_t  data_wsel_i,
	output logic            data_stall_o,
	output logic            data_rvalid_o,
	output mem_pkg::word_t  data_rdata_o,
	// memory bus
	output logic            bus_req_o,
	output mem_pkg::paddr_t bus_addr_o,
	output logic            bus_uncached_o,
	output logic            bus_we_o,
	output mem_pkg::word_t  bus_wdata_o,
	output mem_pkg::wsel_t  bus_wsel_o,
	input  logic            bus_ack_i,
	input  mem_pkg::word_t  bus_rdata_i
);
	import mem_pkg::*;

	// fetch port to arbiter
	logic   ireq;
	paddr_t ipaddr;
	logic   iuncached;
	logic   idone;
	word_t  irdata;
	// data port to arbiter
	logic   dreq;
	paddr_t dpaddr;
	logic   duncached;
	logic   dwe;
	word_t  dwdata;
	wsel_t  dwsel;
	logic   ddone;
	word_t  drdata;

	fetch_port u_fetch (
		.clk           (clk),
		.rst           (rst),
		.inst_req_i    (inst_req_i),
		.inst_vaddr_i  (inst_vaddr_i),
		.flush_i       (flush_i),
		.redirect_pc_i (redirect_pc_i),
		.ireq_o        (ireq),
		.ipaddr_o      (ipaddr),
		.iuncached_o   (iuncached),
		.idone_i       (idone),
		.irdata_i      (irdata),
		.inst_valid_o  (inst_valid_o),
		.inst_o        (inst_o),
		.inst_addr_o   (inst_addr_o),
		.npc_o         (npc_o)
	);

	data_port u_data (
		.clk           (clk),
		.rst           (rst),
		.data_rreq_i   (data_rreq_i),
		.data_raddr_i  (data_raddr_i),
		.data_wreq_i   (data_wreq_i),
		.data_waddr_i  (data_waddr_i),
		.data_wdata_i  (data_wdata_i),
		.data_wsel_i   (data_wsel_i),
		.dreq_o        (dreq),
		.dpaddr_o      (dpaddr),
		.duncached_o   (duncached),
		.dwe_o         (dwe),
		.dwdata_o      (dwdata),
		.dwsel_o       (dwsel),
		.ddone_i       (ddone),
		.drdata_i      (drdata),
		.data_stall_o  (data_stall_o),
		.data_rvalid_o (data_rvalid_o),
		.data_rdata_o  (data_rdata_o)
	);

	// single bus shared by both ports
	bus_arbiter u_arb (
		.clk            (clk),
		.rst            (rst),
		.ireq_i         (ireq),
		.ipaddr_i       (ipaddr),
		.iuncached_i    (iuncached),
		.idone_o        (idone),
		.irdata_o       (irdata),
		.dreq_i         (dreq),
		.dpaddr_i       (dpaddr),
		.duncached_i    (duncached),
		.dwe_i          (dwe),
		.dwdata_i       (dwdata),
		.dwsel_i        (dwsel),
		.ddone_o        (ddone),
		.drdata_o       (drdata),
		.bus_req_o      (bus_req_o),
		.bus_addr_o     (bus_addr_o),
		.bus_uncached_o (bus_uncached_o),
		.bus_we_o       (bus_we_o),
		.bus_wdata_o    (bus_wdata_o),
		.bus_wsel_o     (bus_wsel_o),
		.bus_ack_i      (bus_ack_i),
		.bus_rdata_i    (bus_rdata_i)
	);

endmodule

`default_nettype wire

//--- hdl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

////////////////////////////////////////
// segment map
////////////////////////////////////////

// kseg0, cached window onto low physical memory
`define MEM_KSEG0_BASE 32'h8000_0000
// kseg1, same window but uncached
`define MEM_KSEG1_BASE 32'hA000_0000
// end of both unmapped kernel segments
`define MEM_KSEG2_BASE 32'hC000_0000
// keeps the low 29 bits
`define MEM_PHYS_MASK 32'h1FFF_FFFF

// boot vector in kseg1, and the single-instruction step
`define MEM_RESET_PC 32'hBFC0_0000
`define MEM_INST_STEP 32'd4

`endif

//--- hdl/mem_pkg.sv
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

	// virtual address as issued by the cpu
	typedef logic [`MEM_ADDR_W-1:0] vaddr_t;

	// physical address after segment translation
	typedef logic [`MEM_ADDR_W-1:0] paddr_t;

	// one data or instruction word
	typedef logic [`MEM_DATA_W-1:0] word_t;

	// byte enables, one per byte lane
	typedef logic [3:0] wsel_t;

	// arbiter owner of the shared bus
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_INST,
		ARB_DATA
	} arb_state_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_mem_access -o tb_mem_access

out=$(./obj_dir/tb_mem_access)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

//--- tests/tb_mem_access.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_access;
	import mem_pkg::*;

	// row operations
	localparam int OP_FETCH = 0;
	localparam int OP_READ  = 1;
	localparam int OP_WRITE = 2;
	localparam int OP_FLUSH = 3;
	localparam int OP_BOTH  = 4;
	localparam int NROWS    = 13;
	localparam int TIMEOUT  = 50;
	// memory returns paddr xor this
	localparam word_t RD_KEY = 32'h5A5A_5A5A;

	logic   clk = 1'b0;
	logic   rst;
	logic   inst_req_i;
	vaddr_t inst_vaddr_i;
	logic   flush_i;
	vaddr_t redirect_pc_i;
	logic   inst_valid_o;
	word_t  inst_o;
	vaddr_t inst_addr_o;
	vaddr_t npc_o;
	logic   data_rreq_i;
	vaddr_t data_raddr_i;
	logic   data_wreq_i;
	vaddr_t data_waddr_i;
	word_t  data_wdata_i;
	wsel_t  data_wsel_i;
	logic   data_stall_o;
	logic   data_rvalid_o;
	word_t  data_rdata_o;
	logic   bus_req_o;
	paddr_t bus_addr_o;
	logic   bus_uncached_o;
	logic   bus_we_o;
	word_t  bus_wdata_o;
	wsel_t  bus_wsel_o;
	logic   bus_ack_i = 1'b0;
	word_t  bus_rdata_i = '0;

	// stimulus table with one array per column
	int     row_op    [NROWS];
	vaddr_t row_vaddr [NROWS];
	word_t  row_wdata [NROWS];
	wsel_t  row_wsel  [NROWS];
	vaddr_t row_redir [NROWS];
	paddr_t row_paddr [NROWS];
	logic   row_unc   [NROWS];

	// every bus access seen by the memory model
	paddr_t log_addr  [$];
	logic   log_unc   [$];
	logic   log_we    [$];
	word_t  log_wdata [$];
	wsel_t  log_wsel  [$];
	paddr_t mem_addr;
	int     lat_left = 0;
	int     ack_count = 0;
	int     errors;
	int     timeouts;

	mem_access_top dut0 (
		.clk            (clk),
		.rst            (rst),
		.inst_req_i     (inst_req_i),
		.inst_vaddr_i   (inst_vaddr_i),
		.flush_i        (flush_i),
		.redirect_pc_i  (redirect_pc_i),
		.inst_valid_o   (inst_valid_o),
		.inst_o         (inst_o),
		.inst_addr_o    (inst_addr_o),
		.npc_o          (npc_o),
		.data_rreq_i    (data_rreq_i),
		.data_raddr_i   (data_raddr_i),
		.data_wreq_i    (data_wreq_i),
		.data_waddr_i   (data_waddr_i),
		.data_wdata_i   (data_wdata_i),
		.data_wsel_i    (data_wsel_i),
		.data_stall_o   (data_stall_o),
		.data_rvalid_o  (data_rvalid_o),
		.data_rdata_o   (data_rdata_o),
		.bus_req_o      (bus_req_o),
		.bus_addr_o     (bus_addr_o),
		.bus_uncached_o (bus_uncached_o),
		.bus_we_o       (bus_we_o),
		.bus_wdata_o    (bus_wdata_o),
		.bus_wsel_o     (bus_wsel_o),
		.bus_ack_i      (bus_ack_i),
		.bus_rdata_i    (bus_rdata_i)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////////////////////////
	// memory model
	////////////////////////////////////////

	// request seen on a falling edge and acked 1 to 4 cycles later
	always @(negedge clk) begin
		bus_ack_i = 1'b0;
		if (rst) begin
			lat_left = 0;
		end else if (bus_req_o) begin
			mem_addr = bus_addr_o;
			lat_left = 1 + ($urandom % 4);
			log_addr.push_back(bus_addr_o);
			log_unc.push_back(bus_uncached_o);
			log_we.push_back(bus_we_o);
			log_wdata.push_back(bus_wdata_o);
			log_wsel.push_back(bus_wsel_o);
		end else if (lat_left > 0) begin
			lat_left = lat_left - 1;
			if (lat_left == 0) begin
				bus_ack_i   = 1'b1;
				bus_rdata_i = mem_addr ^ RD_KEY;
			end
		end
	end

	// acks counted on the rising edge where the dut samples them
	always @(posedge clk) begin
		if (bus_ack_i)
			ack_count <= ack_count + 1;
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what, input int r);
		timeouts++;
		$display("timeout in row %0d at %0t: %s never arrived", r, $time, what);
	endtask

	// compare one logged bus access against the expected fields
	task automatic check_bus(input int idx, input paddr_t addr, input logic unc,
			input logic we, input word_t wdata, input wsel_t wsel);
		assert (idx < log_addr.size()) else begin
			errors++;
			$display("bus access %0d was never issued", idx);
		end
		if (idx < log_addr.size()) begin
			check_value("bus_addr_o", log_addr[idx], addr);
			check_value("bus_uncached_o", word_t'(log_unc[idx]), word_t'(unc));
			check_value("bus_we_o", word_t'(log_we[idx]), word_t'(we));
			check_value("bus_wsel_o", word_t'(log_wsel[idx]), word_t'(wsel));
			// write data only means something on a write
			if (we)
				check_value("bus_wdata_o", log_wdata[idx], wdata);
		end
	endtask

	task automatic set_row(input int r, input int op, input vaddr_t va, input word_t wd,
			input wsel_t ws, input vaddr_t redir, input paddr_t pa, input logic unc);
		row_op[r]    = op;
		row_vaddr[r] = va;
		row_wdata[r] = wd;
		row_wsel[r]  = ws;
		row_redir[r] = redir;
		row_paddr[r] = pa;
		row_unc[r]   = unc;
	endtask

	////////////////////////////////////////
	// row operations that each start on a falling edge
	////////////////////////////////////////

	task automatic fetch_word(input int r);
		int n;
		int base;
		base         = log_addr.size();
		inst_req_i   = 1'b1;
		inst_vaddr_i = row_vaddr[r];
		@(negedge clk);
		inst_req_i = 1'b0;
		n = 0;
		while (!inst_valid_o && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!inst_valid_o) begin
			report_timeout("inst_valid_o", r);
		end else begin
			check_value("inst_o", inst_o, row_paddr[r] ^ RD_KEY);
			check_value("inst_addr_o", inst_addr_o, row_vaddr[r]);
			// npc steps one cycle after the valid pulse
			@(negedge clk);
			check_value("npc_o", npc_o, row_vaddr[r] + `MEM_INST_STEP);
			check_bus(base, row_paddr[r], row_unc[r], 1'b0, '0, 4'hF);
		end
	endtask

	task automatic read_word(input int r);
		int n;
		int base;
		base         = log_addr.size();
		data_rreq_i  = 1'b1;
		data_raddr_i = row_vaddr[r];
		@(negedge clk);
		data_rreq_i = 1'b0;
		check_value("data_stall_o", word_t'(data_stall_o), 32'd1);
		n = 0;
		while (!data_rvalid_o && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!data_rvalid_o) begin
			report_timeout("data_rvalid_o", r);
		end else begin
			check_value("data_stall_o", word_t'(data_stall_o), 32'd0);
			check_value("data_rdata_o", data_rdata_o, row_paddr[r] ^ RD_KEY);
			check_bus(base, row_paddr[r], row_unc[r], 1'b0, '0, 4'hF);
		end
	endtask

	task automatic write_word(input int r);
		int n;
		int base;
		int acks0;
		base         = log_addr.size();
		acks0        = ack_count;
		data_wreq_i  = 1'b1;
		data_waddr_i = row_vaddr[r];
		data_wdata_i = row_wdata[r];
		data_wsel_i  = row_wsel[r];
		@(negedge clk);
		data_wreq_i = 1'b0;
		check_value("data_stall_o", word_t'(data_stall_o), 32'd1);
		n = 0;
		while (data_stall_o && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (data_stall_o) begin
			report_timeout("stall release", r);
		end else begin
			// release only after the memory acked
			check_value("bus_ack_i count", ack_count, acks0 + 1);
			check_bus(base, row_paddr[r], row_unc[r], 1'b1, row_wdata[r], row_wsel[r]);
		end
	endtask

	task automatic flush_fetch(input int r);
		int   n;
		int   base;
		int   acks0;
		logic saw;
		base         = log_addr.size();
		acks0        = ack_count;
		saw          = 1'b0;
		inst_req_i   = 1'b1;
		inst_vaddr_i = row_vaddr[r];
		@(negedge clk);
		// fetch is now outstanding
		inst_req_i    = 1'b0;
		flush_i       = 1'b1;
		redirect_pc_i = row_redir[r];
		@(negedge clk);
		flush_i = 1'b0;
		n = 0;
		while (ack_count == acks0 && n < TIMEOUT) begin
			if (inst_valid_o)
				saw = 1'b1;
			@(negedge clk);
			n++;
		end
		if (ack_count == acks0) begin
			report_timeout("bus_ack_i for the flushed fetch", r);
		end else begin
			// cycle after the ack is where a valid would land
			if (inst_valid_o)
				saw = 1'b1;
			assert (!saw) else begin
				errors++;
				$display("inst_valid_o pulsed for a flushed fetch in row %0d", r);
			end
			check_value("npc_o", npc_o, row_redir[r]);
			check_bus(base, row_paddr[r], row_unc[r], 1'b0, '0, 4'hF);
		end
	endtask

	// read sits 0x40 above the fetch in the same segment
	task automatic fetch_and_read(input int r);
		int   n;
		int   base;
		logic got_i;
		logic got_d;
		base         = log_addr.size();
		got_i        = 1'b0;
		got_d        = 1'b0;
		inst_req_i   = 1'b1;
		inst_vaddr_i = row_vaddr[r];
		data_rreq_i  = 1'b1;
		data_raddr_i = row_vaddr[r] + 32'h40;
		@(negedge clk);
		inst_req_i  = 1'b0;
		data_rreq_i = 1'b0;
		n = 0;
		while (!(got_i && got_d) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
			if (inst_valid_o) begin
				got_i = 1'b1;
				check_value("inst_o", inst_o, row_paddr[r] ^ RD_KEY);
				check_value("inst_addr_o", inst_addr_o, row_vaddr[r]);
			end
			if (data_rvalid_o) begin
				got_d = 1'b1;
				check_value("data_rdata_o", data_rdata_o, (row_paddr[r] + 32'h40) ^ RD_KEY);
			end
		end
		if (!(got_i && got_d)) begin
			report_timeout("inst_valid_o or data_rvalid_o", r);
		end else begin
			// data goes first on the bus
			check_bus(base, row_paddr[r] + 32'h40, row_unc[r], 1'b0, '0, 4'hF);
			check_bus(base + 1, row_paddr[r], row_unc[r], 1'b0, '0, 4'hF);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(32'h706a_f25b));
		errors        = 0;
		timeouts      = 0;
		rst           = 1'b1;
		inst_req_i    = 1'b0;
		inst_vaddr_i  = '0;
		flush_i       = 1'b0;
		redirect_pc_i = '0;
		data_rreq_i   = 1'b0;
		data_raddr_i  = '0;
		data_wreq_i   = 1'b0;
		data_waddr_i  = '0;
		data_wdata_i  = '0;
		data_wsel_i   = '0;

		// op, vaddr, wdata, wsel, redirect, paddr, uncached
		set_row(0, OP_FETCH, 32'h0000_1000, '0, '0, '0, 32'h0000_1000, 1'b0);
		set_row(1, OP_FETCH, 32'h8000_0200, '0, '0, '0, 32'h0000_0200, 1'b0);
		set_row(2, OP_FETCH, 32'hBFC0_0000, '0, '0, '0, 32'h1FC0_0000, 1'b1);
		set_row(3, OP_READ, 32'h0000_2040, '0, '0, '0, 32'h0000_2040, 1'b0);
		set_row(4, OP_READ, 32'h8000_3000, '0, '0, '0, 32'h0000_3000, 1'b0);
		set_row(5, OP_READ, 32'hA000_4008, '0, '0, '0, 32'h0000_4008, 1'b1);
		set_row(6, OP_READ, 32'hC000_1000, '0, '0, '0, 32'hC000_1000, 1'b0);
		set_row(7, OP_WRITE, 32'h8010_0010, 32'hDEAD_BEEF, 4'b0011, '0, 32'h0010_0010, 1'b0);
		set_row(8, OP_WRITE, 32'hB000_0020, 32'h1234_5678, 4'hF, '0, 32'h1000_0020, 1'b1);
		set_row(9, OP_WRITE, 32'h0000_5000, 32'hCAFE_0001, 4'b1000, '0, 32'h0000_5000, 1'b0);
		set_row(10, OP_FLUSH, 32'h8000_0100, '0, '0, 32'h8000_0400, 32'h0000_0100, 1'b0);
		set_row(11, OP_FETCH, 32'h8000_0400, '0, '0, '0, 32'h0000_0400, 1'b0);
		set_row(12, OP_BOTH, 32'h8000_0800, '0, '0, '0, 32'h0000_0800, 1'b0);

		// three cycles of reset
		repeat (3) @(negedge clk);
		check_value("inst_valid_o", word_t'(inst_valid_o), 32'd0);
		check_value("data_rvalid_o", word_t'(data_rvalid_o), 32'd0);
		check_value("data_stall_o", word_t'(data_stall_o), 32'd0);
		check_value("bus_req_o", word_t'(bus_req_o), 32'd0);
		check_value("npc_o", npc_o, `MEM_RESET_PC);
		rst = 1'b0;
		@(negedge clk);

		for (int r = 0; r < NROWS; r++) begin
			case (row_op[r])
				OP_FETCH: fetch_word(r);
				OP_READ:  read_word(r);
				OP_WRITE: write_word(r);
				OP_FLUSH: flush_fetch(r);
				default:  fetch_and_read(r);
			endcase
			@(negedge clk);
		end

		$display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
